// File: test/me_testdata.txt
# name kind area_fill(hex) block_fill(hex) cand_row cand_col gap exp_x exp_y
# rand: random area, block copied from the window; flat: area_fill with a block_fill window
exact_match   rand 00 00 2 1 0 -1  0
all_tie       flat 5a 5a 2 2 0 -2  2
corner        rand 00 00 4 4 0  2 -2
large_sums    flat 00 ff 0 4 0  2  2
gap_match     rand 00 00 2 1 1 -1  0
back_to_back  rand 00 00 3 0 0 -2 -1

// File: sources.f
common/me_pkg.sv
hdl/block_buffer.sv
sad_array/sad_cell.sv
sad_array/sad_array.sv
hdl/min_search.sv
hdl/me_top.sv
test/me_assert.sv
test/me_tb.sv

// File: Makefile
# Verilator build and run of the motion estimator testbench

VERILATOR  ?= verilator
TOP        ?= me_tb
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Regression passed
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_ARGS   ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

# pass only when the log holds the pass line
run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/me_tb.sv
`timescale 1ns/1ns

module me_tb;

    localparam int CLK_HALF    = 20;
    localparam int RESET_CYC   = 5;
    localparam int MAX_TESTS   = 16;
    localparam int AREA_PIX    = me_pkg::AREA_DIM * me_pkg::AREA_DIM;
    // cycle budget of one job, also the watchdog unit
    localparam int JOB_CYC     = me_pkg::BLOCK_PIX + AREA_PIX * 2 + 40;
    // last area sample to first output cycle
    localparam int OUT_LATENCY = 27;

    logic           clk;
    logic           rst_n;
    logic           block_valid;
    logic           area_valid;
    me_pkg::pixel_t in_data;
    logic           out_valid;
    me_pkg::mv_t    out_vector;

    // ------------------------------------------------------------------
    // test table, one entry per data line
    // ------------------------------------------------------------------

    string t_name [MAX_TESTS];
    string t_kind [MAX_TESTS];
    int    t_area_fill [MAX_TESTS];
    int    t_block_fill [MAX_TESTS];
    int    t_row [MAX_TESTS];
    int    t_col [MAX_TESTS];
    int    t_gap [MAX_TESTS];
    int    t_exp_x [MAX_TESTS];
    int    t_exp_y [MAX_TESTS];
    int    num_tests;
    bit    tests_loaded;

    // pixels of the job in flight
    me_pkg::pixel_t area_pix [AREA_PIX];
    me_pkg::pixel_t blk_pix [me_pkg::BLOCK_PIX];

    string cur_test;
    int    error_count;
    int    pass_count;

    me_top i_me_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .block_valid (block_valid),
        .area_valid  (area_valid),
        .in_data     (in_data),
        .out_valid   (out_valid),
        .out_vector  (out_vector)
    );

    always #CLK_HALF clk = ~clk;

    task automatic check_value(input string what, input int actual, input int expected);
        if (actual != expected) begin
            $display("ERROR @ %0t ns: %s: %s is %0d, expected %0d",
                     $time, cur_test, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic load_tests();
        int    fd;
        int    n;
        string line;
        string name;
        string kind;
        int    af;
        int    bf;
        int    row;
        int    col;
        int    gap;
        int    ex;
        int    ey;
        fd = $fopen("test/me_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open test/me_testdata.txt");
            return;
        end
        while (!$feof(fd) && num_tests < MAX_TESTS) begin
            line = "";
            void'($fgets(line, fd));
            // skip blanks and column notes
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %s %h %h %d %d %d %d %d",
                        name, kind, af, bf, row, col, gap, ex, ey);
            if (n == 9) begin
                t_name[num_tests]       = name;
                t_kind[num_tests]       = kind;
                t_area_fill[num_tests]  = af;
                t_block_fill[num_tests] = bf;
                t_row[num_tests]        = row;
                t_col[num_tests]        = col;
                t_gap[num_tests]        = gap;
                t_exp_x[num_tests]      = ex;
                t_exp_y[num_tests]      = ey;
                num_tests++;
            end
        end
        $fclose(fd);
    endtask

    // area pattern, then the block cut out of the chosen window
    task automatic build_job(input int t);
        int idx;
        for (int i = 0; i < AREA_PIX; i++) begin
            if (t_kind[t] == "rand") begin
                area_pix[i] = me_pkg::pixel_t'($urandom);
            end else begin
                area_pix[i] = me_pkg::pixel_t'(t_area_fill[t]);
            end
        end
        for (int p = 0; p < me_pkg::BLOCK_PIX; p++) begin
            idx = (t_row[t] + p / me_pkg::BLOCK_DIM) * me_pkg::AREA_DIM
                + t_col[t] + p % me_pkg::BLOCK_DIM;
            // flat kind paints the window with the block value
            if (t_kind[t] != "rand") begin
                area_pix[idx] = me_pkg::pixel_t'(t_block_fill[t]);
            end
            blk_pix[p] = area_pix[idx];
        end
    endtask

    // one sample on the falling edge, optional hole before it
    task automatic send_pixel(input logic to_block, input me_pkg::pixel_t value, input bit gap);
        int idle;
        idle = gap ? int'($urandom % 2) : 0;
        repeat (idle) begin
            @(negedge clk);
            block_valid = 1'b0;
            area_valid  = 1'b0;
        end
        @(negedge clk);
        block_valid = to_block;
        area_valid  = !to_block;
        in_data     = value;
    endtask

    task automatic run_test(input int t);
        int errs_before;
        int cycles;
        errs_before = error_count;
        cur_test    = t_name[t];
        build_job(t);
        for (int p = 0; p < me_pkg::BLOCK_PIX; p++) begin
            send_pixel(1'b1, blk_pix[p], t_gap[t] != 0);
        end
        for (int i = 0; i < AREA_PIX; i++) begin
            send_pixel(1'b0, area_pix[i], t_gap[t] != 0);
        end
        @(negedge clk);
        block_valid = 1'b0;
        area_valid  = 1'b0;
        in_data     = '0;
        // count edges from the last area sample until the vector shows
        cycles = 0;
        while (!out_valid && cycles < JOB_CYC) begin
            @(negedge clk);
            cycles++;
        end
        if (!out_valid) begin
            $display("%s: no motion vector came out within %0d cycles", cur_test, JOB_CYC);
            error_count++;
        end else begin
            check_value("latency", cycles, OUT_LATENCY);
            check_value("x", int'(out_vector), t_exp_x[t]);
            @(negedge clk);
            check_value("out_valid on y cycle", int'(out_valid), 1);
            check_value("y", int'(out_vector), t_exp_y[t]);
            @(negedge clk);
            check_value("out_valid after y", int'(out_valid), 0);
        end
        if (error_count == errs_before) begin
            pass_count++;
            $display("test %-14s ok      (%0d, %0d)", cur_test, t_exp_x[t], t_exp_y[t]);
        end else begin
            $display("test %-14s FAIL", cur_test);
        end
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        block_valid = 1'b0;
        area_valid  = 1'b0;
        in_data     = '0;
        num_tests   = 0;
        error_count = 0;
        pass_count  = 0;
        void'($urandom(32'h9d6e));
        load_tests();
        tests_loaded = 1'b1;
        repeat (RESET_CYC) @(negedge clk);
        rst_n = 1'b1;
        if (num_tests == 0) begin
            $display("no tests were read from the data file");
            error_count++;
        end
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        // failed bound assertions count as errors too
        if (i_me_top.i_me_assert.fail_count != 0) begin
            $display("%0d assertion failures seen", i_me_top.i_me_assert.fail_count);
            error_count += i_me_top.i_me_assert.fail_count;
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 num_tests, pass_count, num_tests - pass_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // watchdog, budget scales with the number of tests
    initial begin
        wait (tests_loaded);
        #((RESET_CYC + (num_tests + 1) * JOB_CYC) * 2 * CLK_HALF);
        $display("timeout: the tests did not finish in the allowed time");
        $display("Regression failed");
        $finish;
    end

endmodule

// File: test/me_assert.sv
`timescale 1ns/1ns

module me_assert (
    input logic        clk,
    input logic        rst_n,
    input logic        block_valid,
    input logic        area_valid,
    input logic        out_valid,
    input me_pkg::mv_t out_vector
);

    // failures per rule, summed for the testbench
    int long_valid_cnt = 0;
    int idle_vec_cnt   = 0;
    int range_cnt      = 0;
    int overlap_cnt    = 0;
    int fail_count;

    assign fail_count = long_valid_cnt + idle_vec_cnt + range_cnt + overlap_cnt;

    // ------------------------------------------------------------------
    // output protocol
    // ------------------------------------------------------------------

    // x then y, never a third cycle
    a_valid_len: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && $past(out_valid) |=> !out_valid)
    else begin
        $error("out_valid held longer than two cycles");
        long_valid_cnt++;
    end

    a_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> out_vector == '0)
    else begin
        $error("out_vector not zero while out_valid is low");
        idle_vec_cnt++;
    end

    // components stay in -2..2
    a_range: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (int'(out_vector) >= -2) && (int'(out_vector) <= 2))
    else begin
        $error("out_vector outside the search range");
        range_cnt++;
    end

    // ------------------------------------------------------------------
    // input rules
    // ------------------------------------------------------------------

    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !(block_valid && area_valid))
    else begin
        $error("block_valid and area_valid high together");
        overlap_cnt++;
    end

endmodule

bind me_top me_assert i_me_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .block_valid (block_valid),
    .area_valid  (area_valid),
    .out_valid   (out_valid),
    .out_vector  (out_vector)
);

// File: hdl/me_top.sv
`timescale 1ns/1ns

module me_top (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           block_valid,
    input  logic           area_valid,
    input  me_pkg::pixel_t in_data,
    output logic           out_valid,
    output me_pkg::mv_t    out_vector
);

    // block pixels and job start
    me_pkg::block_flat_t block;
    logic                block_start;
    // finished sums
    me_pkg::sad_vec_t    sums;
    logic                sums_done;

    // ------------------------------------------------------------------
    // block capture
    // ------------------------------------------------------------------

    block_buffer i_block_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .block_valid (block_valid),
        .in_data     (in_data),
        .block       (block),
        .block_start (block_start)
    );

    // SAD accumulation over the area
    sad_array i_sad_array (
        .clk         (clk),
        .rst_n       (rst_n),
        .area_valid  (area_valid),
        .in_data     (in_data),
        .block       (block),
        .block_start (block_start),
        .sums        (sums),
        .sums_done   (sums_done)
    );

    // best candidate and vector out
    min_search i_min_search (
        .clk        (clk),
        .rst_n      (rst_n),
        .sums       (sums),
        .sums_done  (sums_done),
        .out_valid  (out_valid),
        .out_vector (out_vector)
    );

endmodule

// File: hdl/min_search.sv
`timescale 1ns/1ns

module min_search (
    input  logic             clk,
    input  logic             rst_n,
    input  me_pkg::sad_vec_t sums,
    input  logic             sums_done,
    output logic             out_valid,
    output me_pkg::mv_t      out_vector
);

    localparam int IDX_W = $clog2(me_pkg::NUM_CAND);

    me_pkg::search_state_t state;
    logic [IDX_W-1:0]      cand_idx;
    logic [IDX_W-1:0]      min_idx;
    me_pkg::sad_t          min_sad;
    me_pkg::sad_t          cur_sad;
    me_pkg::mv_t           vec_x;
    me_pkg::mv_t           vec_y;

    // sum under the scan pointer
    assign cur_sad = sums[cand_idx*me_pkg::SAD_W +: me_pkg::SAD_W];

    // winner index to vector, col gives x, row gives y
    assign vec_x = me_pkg::mv_t'(int'(min_idx % me_pkg::SEARCH_DIM) - me_pkg::SEARCH_RANGE);
    assign vec_y = me_pkg::mv_t'(me_pkg::SEARCH_RANGE - int'(min_idx / me_pkg::SEARCH_DIM));

    // ------------------------------------------------------------------
    // scan FSM
    // ------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= me_pkg::IDLE;
            cand_idx <= '0;
        end else begin
            case (state)
                me_pkg::IDLE: begin
                    if (sums_done) begin
                        state    <= me_pkg::SCAN;
                        cand_idx <= '0;
                    end
                end
                me_pkg::SCAN: begin
                    // one candidate per cycle, 0..24
                    if (cand_idx == IDX_W'(me_pkg::NUM_CAND - 1)) begin
                        state    <= me_pkg::EMIT_X;
                        cand_idx <= '0;
                    end else begin
                        cand_idx <= cand_idx + 1'b1;
                    end
                end
                me_pkg::EMIT_X: state <= me_pkg::EMIT_Y;
                me_pkg::EMIT_Y: state <= me_pkg::IDLE;
                default:        state <= me_pkg::IDLE;
            endcase
        end
    end

    // running minimum
    always_ff @(posedge clk) begin
        if (state == me_pkg::IDLE && sums_done) begin
            // above any real sum, so candidate 0 always loads
            min_sad <= '1;
        end else if (state == me_pkg::SCAN && cur_sad < min_sad) begin
            // strict compare, lowest index keeps a tie
            min_sad <= cur_sad;
            min_idx <= cand_idx;
        end
    end

    // ------------------------------------------------------------------
    // output, x then y
    // ------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            out_vector <= '0;
        end else begin
            out_valid  <= (state == me_pkg::EMIT_X) || (state == me_pkg::EMIT_Y);
            // zero outside the two output cycles
            out_vector <= (state == me_pkg::EMIT_X) ? vec_x :
                          (state == me_pkg::EMIT_Y) ? vec_y : '0;
        end
    end

endmodule

// File: sad_array/sad_array.sv
`timescale 1ns/1ns

module sad_array (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                area_valid,
    input  me_pkg::pixel_t      in_data,
    input  me_pkg::block_flat_t block,
    input  logic                block_start,
    output me_pkg::sad_vec_t    sums,
    output logic                sums_done
);

    // ------------------------------------------------------------------
    // area position
    // ------------------------------------------------------------------

    // raster position of the sample on in_data
    me_pkg::coord_t area_row;
    me_pkg::coord_t area_col;
    logic           row_end;
    logic           last_sample;

    // last column of a row
    assign row_end     = (area_col == me_pkg::coord_t'(me_pkg::AREA_DIM - 1));
    // bottom right sample closes the area
    assign last_sample = area_valid && row_end &&
                         (area_row == me_pkg::coord_t'(me_pkg::AREA_DIM - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            area_row <= '0;
            area_col <= '0;
        end else if (block_start) begin
            // new job, restart at the top left
            area_row <= '0;
            area_col <= '0;
        end else if (area_valid) begin
            area_col <= area_col + 1'b1;
            // wraps to zero after row 7
            if (row_end) begin
                area_row <= area_row + 1'b1;
            end
        end
    end

    // one cycle after the 64th sample is taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sums_done <= 1'b0;
        end else begin
            sums_done <= last_sample;
        end
    end

    // ------------------------------------------------------------------
    // candidate cells
    // ------------------------------------------------------------------

    // one accumulator per displacement, c = 5*row + col
    for (genvar r = 0; r < me_pkg::SEARCH_DIM; r++) begin : g_row
        for (genvar c = 0; c < me_pkg::SEARCH_DIM; c++) begin : g_col
            sad_cell #(
                .CAND_ROW (r),
                .CAND_COL (c)
            ) i_sad_cell (
                .clk          (clk),
                .rst_n        (rst_n),
                .clear        (block_start),
                .sample_valid (area_valid),
                .area_row     (area_row),
                .area_col     (area_col),
                .sample       (in_data),
                .block        (block),
                .sum          (sums[(r*me_pkg::SEARCH_DIM+c)*me_pkg::SAD_W +: me_pkg::SAD_W])
            );
        end
    end

endmodule

// File: sad_array/sad_cell.sv
`timescale 1ns/1ns

module sad_cell #(
    parameter int CAND_ROW = 0,
    parameter int CAND_COL = 0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                clear,
    input  logic                sample_valid,
    input  me_pkg::coord_t      area_row,
    input  me_pkg::coord_t      area_col,
    input  me_pkg::pixel_t      sample,
    input  me_pkg::block_flat_t block,
    output me_pkg::sad_t        sum
);

    // window covers rows CAND_ROW..+3, cols CAND_COL..+3
    localparam me_pkg::coord_t ROW_LO = me_pkg::coord_t'(CAND_ROW);
    localparam me_pkg::coord_t ROW_HI = me_pkg::coord_t'(CAND_ROW + me_pkg::BLOCK_DIM - 1);
    localparam me_pkg::coord_t COL_LO = me_pkg::coord_t'(CAND_COL);
    localparam me_pkg::coord_t COL_HI = me_pkg::coord_t'(CAND_COL + me_pkg::BLOCK_DIM - 1);

    logic             in_win;
    me_pkg::coord_t   rel_row;
    me_pkg::coord_t   rel_col;
    me_pkg::blk_idx_t blk_idx;
    me_pkg::pixel_t   ref_pix;
    me_pkg::pixel_t   abs_diff;

    assign in_win = (area_row >= ROW_LO) && (area_row <= ROW_HI) &&
                    (area_col >= COL_LO) && (area_col <= COL_HI);

    // position inside the block, only meaningful in the window
    assign rel_row = area_row - ROW_LO;
    assign rel_col = area_col - COL_LO;
    assign blk_idx = me_pkg::blk_idx_t'(rel_row * me_pkg::BLOCK_DIM + rel_col);
    assign ref_pix = block[blk_idx*me_pkg::PIXEL_W +: me_pkg::PIXEL_W];

    // |sample - ref| without a sign bit
    assign abs_diff = (sample > ref_pix) ? (sample - ref_pix) : (ref_pix - sample);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum <= '0;
        end else if (clear) begin
            sum <= '0;
        end else if (sample_valid && in_win) begin
            // holes in sample_valid leave the sum alone
            sum <= sum + me_pkg::sad_t'(abs_diff);
        end
    end

endmodule

// File: hdl/block_buffer.sv
`timescale 1ns/1ns

module block_buffer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                block_valid,
    input  me_pkg::pixel_t      in_data,
    output me_pkg::block_flat_t block,
    output logic                block_start
);

    // ------------------------------------------------------------------
    // storage
    // ------------------------------------------------------------------

    // 16 block pixels, raster order
    me_pkg::pixel_t   mem [me_pkg::BLOCK_PIX];
    // next slot to write, wraps after 16
    me_pkg::blk_idx_t wr_idx;

    // first pixel of a new block
    assign block_start = block_valid && (wr_idx == '0);

    // write index
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_idx <= '0;
        end else if (block_valid) begin
            wr_idx <= wr_idx + 1'b1;
        end
    end

    // pixel capture
    always_ff @(posedge clk) begin
        if (block_valid) begin
            mem[wr_idx] <= in_data;
        end
    end

    // ------------------------------------------------------------------
    // flatten for the cells
    // ------------------------------------------------------------------

    // every cell sees all 16 pixels at once
    always_comb begin
        for (int i = 0; i < me_pkg::BLOCK_PIX; i++) begin
            block[i*me_pkg::PIXEL_W +: me_pkg::PIXEL_W] = mem[i];
        end
    end

endmodule

// File: common/me_pkg.sv
package me_pkg;

    // ------------------------------------------------------------------
    // dimensions
    // ------------------------------------------------------------------

    // current block is BLOCK_DIM x BLOCK_DIM
    localparam int BLOCK_DIM    = 4;
    localparam int BLOCK_PIX    = BLOCK_DIM * BLOCK_DIM;
    // search area is AREA_DIM x AREA_DIM
    localparam int AREA_DIM     = 8;
    // candidate displacements per axis
    localparam int SEARCH_DIM   = AREA_DIM - BLOCK_DIM + 1;
    localparam int NUM_CAND     = SEARCH_DIM * SEARCH_DIM;
    // vector range is -SEARCH_RANGE..+SEARCH_RANGE
    localparam int SEARCH_RANGE = 2;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------

    localparam int PIXEL_W = 8;
    // 16 x 255 = 4080 fits in 12 bits
    localparam int SAD_W   = 12;
    localparam int COORD_W = 3;
    localparam int BLK_W   = 4;
    localparam int MV_W    = 3;

    // ------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------

    typedef logic [PIXEL_W-1:0] pixel_t;
    typedef logic [SAD_W-1:0] sad_t;
    typedef logic [COORD_W-1:0] coord_t;
    typedef logic [BLK_W-1:0] blk_idx_t;
    // pixel 0 in the lowest byte
    typedef logic [BLOCK_PIX*PIXEL_W-1:0] block_flat_t;
    // candidate c = 5*row + col, c = 0 in the lowest bits
    typedef logic [NUM_CAND*SAD_W-1:0] sad_vec_t;
    typedef logic signed [MV_W-1:0] mv_t;

    // min search FSM
    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        EMIT_X,
        EMIT_Y
    } search_state_t;

endpackage
